//--- common/uart_pkg.sv
package uart_pkg;

	//////////////////////////////
	// Frame format
	//////////////////////////////

	// Data bits per frame, LSB first on the line
	localparam int DATA_BITS = 8;
	// Ticks per bit, stop bit included
	localparam int OVERSAMPLE = 16;

	//////////////////////////////
	// Configuration
	//////////////////////////////

	// Divisor width and reset value
	// 100 MHz / (16 * 9600) = 651
	localparam int DIV_W = 16;
	localparam logic [DIV_W-1:0] DIV_RESET = 16'd651;

	// FIFO depth is 2**FIFO_AW
	localparam int FIFO_AW = 3;

	// Error counters, saturating
	localparam int CNT_W = 8;

	// Config write addresses
	localparam logic CFG_ADDR_DIV = 1'b0;
	localparam logic CFG_ADDR_CLR = 1'b1;

	//////////////////////////////
	// Shared structs
	//////////////////////////////

	// Received byte plus framing flag
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic                 frame_err;
	} rx_word_t;

	// Config write port
	typedef struct packed {
		logic             valid;
		logic             addr;
		logic [DIV_W-1:0] wdata;
	} cfg_wr_t;

	// Error counter readout
	typedef struct packed {
		logic [CNT_W-1:0] overrun_cnt;
		logic [CNT_W-1:0] frame_err_cnt;
	} cfg_status_t;

endpackage

//--- compile.f
common/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_cfg_regs.sv
hdl/sync_fifo.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
hdl/uart_top.sv
tb/uart_tb.sv

//--- hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  AW        = 3
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wr,
	input  payload_t w_data,
	input  logic     rd,
	output payload_t r_data,
	output logic     empty,
	output logic     full
);

	// Entry storage
	payload_t mem [0:(1<<AW)-1];

	// Pointers carry one extra wrap bit
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_wr;
	logic        do_rd;

	//////////////////////////////
	// Flags
	//////////////////////////////

	// Same address, wrap bits equal -> empty
	assign empty = (wr_ptr == rd_ptr);
	// Same address, wrap bits differ -> full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Pop only with data present
	assign do_rd = rd && !empty;
	// Push when room, or when a pop frees the slot this cycle
	assign do_wr = wr && (!full || do_rd);

	// Head always on the read port
	assign r_data = mem[rd_ptr[AW-1:0]];

	//////////////////////////////
	// Storage and pointers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= w_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- hdl/uart_baud_gen.sv
`timescale 1ns/100ps

module uart_baud_gen (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [uart_pkg::DIV_W-1:0] divisor,
	output logic                       tick
);
	import uart_pkg::*;

	// Free-running count and the divisor in use
	logic [DIV_W-1:0] cnt;
	logic [DIV_W-1:0] div_q;
	logic             wrap;

	// Wrap at div_q - 1
	// Divisor 0 or 1 wraps every cycle
	// >= covers a count left past a smaller new divisor
	assign wrap = (div_q <= 1) || (cnt >= div_q - 1'b1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt   <= '0;
			div_q <= DIV_RESET;
			tick  <= 1'b0;
		end else begin
			// One-cycle pulse per wrap
			tick <= wrap;
			if (wrap) begin
				cnt <= '0;
				// New divisor only picked up here
				div_q <= divisor;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- hdl/uart_cfg_regs.sv
`timescale 1ns/100ps

module uart_cfg_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  uart_pkg::cfg_wr_t           cfg,
	input  logic                        rx_done,
	input  logic                        rx_frame_err,
	input  logic                        rx_fifo_full,
	output logic [uart_pkg::DIV_W-1:0]  divisor,
	output uart_pkg::cfg_status_t       status
);
	import uart_pkg::*;

	//////////////////////////////
	// Write decode
	//////////////////////////////

	logic wr_div;
	logic wr_clr;

	assign wr_div = cfg.valid && (cfg.addr == CFG_ADDR_DIV);
	assign wr_clr = cfg.valid && (cfg.addr == CFG_ADDR_CLR);

	// Byte lost when rx_done fires with the rx FIFO full
	logic overrun_ev;
	logic frame_err_ev;

	assign overrun_ev   = rx_done && rx_fifo_full;
	assign frame_err_ev = rx_done && rx_frame_err;

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			divisor <= DIV_RESET;
			status  <= '0;
		end else begin
			if (wr_div)
				divisor <= cfg.wdata;
			// Clear wins over a same-cycle increment
			if (wr_clr) begin
				status <= '0;
			end else begin
				// Saturate at all ones
				if (overrun_ev && (status.overrun_cnt != '1))
					status.overrun_cnt <= status.overrun_cnt + 1'b1;
				if (frame_err_ev && (status.frame_err_cnt != '1))
					status.frame_err_cnt <= status.frame_err_cnt + 1'b1;
			end
		end
	end

endmodule

//--- hdl/uart_top.sv
`timescale 1ns/100ps

module uart_top (
	input  logic                           clk,
	input  logic                           rst_n,
	// Serial line
	input  logic                           rx,
	output logic                           tx,
	// Transmit side
	input  logic                           wr_uart,
	input  logic [uart_pkg::DATA_BITS-1:0] w_data,
	output logic                           tx_full,
	// Receive side
	input  logic                           rd_uart,
	output uart_pkg::rx_word_t             r_word,
	output logic                           rx_empty,
	// Configuration
	input  uart_pkg::cfg_wr_t              cfg,
	output uart_pkg::cfg_status_t          status
);
	import uart_pkg::*;

	logic                 tick;
	logic [DIV_W-1:0]     divisor;
	logic                 rx_done;
	rx_word_t             rx_word;
	logic                 rx_fifo_full;
	logic                 tx_empty;
	logic                 tx_pop;
	logic [DATA_BITS-1:0] tx_fifo_data;

	//////////////////////////////
	// Timing and config
	//////////////////////////////

	uart_baud_gen u_baud_gen (
		.clk     (clk),
		.rst_n   (rst_n),
		.divisor (divisor),
		.tick    (tick)
	);

	uart_cfg_regs u_cfg_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.rx_done      (rx_done),
		.rx_frame_err (rx_word.frame_err),
		.rx_fifo_full (rx_fifo_full),
		.divisor      (divisor),
		.status       (status)
	);

	//////////////////////////////
	// Receive path
	//////////////////////////////

	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.tick    (tick),
		.rx_done (rx_done),
		.rx_word (rx_word)
	);

	// rx_done while full drops the byte
	sync_fifo #(
		.payload_t (rx_word_t),
		.AW        (FIFO_AW)
	) u_rx_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (rx_done),
		.w_data (rx_word),
		.rd     (rd_uart),
		.r_data (r_word),
		.empty  (rx_empty),
		.full   (rx_fifo_full)
	);

	//////////////////////////////
	// Transmit path
	//////////////////////////////

	sync_fifo #(
		.payload_t (logic [DATA_BITS-1:0]),
		.AW        (FIFO_AW)
	) u_tx_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr_uart),
		.w_data (w_data),
		.rd     (tx_pop),
		.r_data (tx_fifo_data),
		.empty  (tx_empty),
		.full   (tx_full)
	);

	uart_tx u_tx (
		.clk        (clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.fifo_empty (tx_empty),
		.fifo_data  (tx_fifo_data),
		.tx_pop     (tx_pop),
		.tx         (tx)
	);

endmodule

//--- tb/uart_tb.sv
`timescale 1ns/100ps

module uart_tb;
	import uart_pkg::*;

	// Divisor for every test after reset
	localparam int TB_DIV   = 3;
	// Clocks per serial bit
	localparam int BIT_CLKS = OVERSAMPLE * TB_DIV;
	// Cycle limit for any wait on the receive FIFO
	localparam int WAIT_MAX = 4000;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 rx;
	logic                 tx;
	logic                 wr_uart;
	logic [DATA_BITS-1:0] w_data;
	logic                 tx_full;
	logic                 rd_uart;
	rx_word_t             r_word;
	logic                 rx_empty;
	cfg_wr_t              cfg;
	cfg_status_t          status;
	// High loops tx back to rx, low selects the bit driver
	logic                 loop_sel;
	logic                 drv_line;
	int                   seed;

	assign rx = loop_sel ? tx : drv_line;

	always #20 clk = ~clk;

	uart_top u_uart_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.tx       (tx),
		.wr_uart  (wr_uart),
		.w_data   (w_data),
		.tx_full  (tx_full),
		.rd_uart  (rd_uart),
		.r_word   (r_word),
		.rx_empty (rx_empty),
		.cfg      (cfg),
		.status   (status)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "Stopped on first error");
	endtask

	task automatic check_eq(input string test, input string what, input int exp, input int act);
		assert (exp == act) else begin
			fail_run($sformatf("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
				test, what, exp, act));
		end
	endtask

	// One config write that the DUT applies on the next edge
	task automatic write_cfg(input logic addr, input logic [DIV_W-1:0] data);
		cfg_wr_t w;
		w.valid = 1'b1;
		w.addr  = addr;
		w.wdata = data;
		@(posedge clk);
		cfg <= w;
		@(posedge clk);
		cfg.valid <= 1'b0;
	endtask

	// Poll at negedge until a word sits in the receive FIFO
	task automatic wait_rx_word(input string test);
		int n;
		n = 0;
		@(negedge clk);
		while (rx_empty) begin
			if (n >= WAIT_MAX)
				fail_run($sformatf("Timeout in %s: receive FIFO stayed empty for %0d cycles",
					test, WAIT_MAX));
			@(negedge clk);
			n++;
		end
	endtask

	// One-cycle read strobe
	task automatic pop_word();
		@(posedge clk);
		rd_uart <= 1'b1;
		@(posedge clk);
		rd_uart <= 1'b0;
	endtask

	task automatic expect_word(input string test, input logic [7:0] data, input logic err);
		wait_rx_word(test);
		check_eq(test, "r_word.data", data, r_word.data);
		check_eq(test, "r_word.frame_err", err, r_word.frame_err);
		pop_word();
	endtask

	// Hold one serial bit for 16 ticks
	task automatic drive_bit(input logic b);
		@(posedge clk);
		drv_line <= b;
		repeat (BIT_CLKS - 1) @(posedge clk);
	endtask

	// Start, 8 data LSB first, stop, then one idle bit
	task automatic drive_frame(input logic [7:0] data, input logic stop_val);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < DATA_BITS; i++)
			drive_bit(data[i]);
		drive_bit(stop_val);
		drive_bit(1'b1);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic check_reset_state();
		@(negedge clk);
		check_eq("reset_state", "tx", 1, tx);
		check_eq("reset_state", "rx_empty", 1, rx_empty);
		check_eq("reset_state", "tx_full", 0, tx_full);
		check_eq("reset_state", "status", 0, status);
	endtask

	task automatic loopback_one_byte();
		logic [7:0] b;
		b = $urandom & 8'hff;
		write_cfg(CFG_ADDR_DIV, TB_DIV);
		@(posedge clk);
		wr_uart <= 1'b1;
		w_data  <= b;
		@(posedge clk);
		wr_uart <= 1'b0;
		expect_word("loopback", b, 1'b0);
	endtask

	task automatic burst_in_order();
		logic [7:0] bytes [0:7];
		int i;
		for (i = 0; i < 8; i++)
			bytes[i] = $urandom & 8'hff;
		// Loopback byte lands mid stop bit, so let that stop bit run out
		repeat (BIT_CLKS) @(posedge clk);
		// Back to back at one per clock
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			wr_uart <= 1'b1;
			w_data  <= bytes[i];
		end
		@(posedge clk);
		wr_uart <= 1'b0;
		@(negedge clk);
		// First byte already popped by the transmitter
		check_eq("burst", "tx_full", 0, tx_full);
		for (i = 0; i < 8; i++)
			expect_word("burst", bytes[i], 1'b0);
	endtask

	task automatic framing_error_frame();
		logic [7:0] b;
		b = $urandom & 8'hff;
		@(posedge clk);
		loop_sel <= 1'b0;
		drive_frame(b, 1'b0);
		wait_rx_word("framing");
		check_eq("framing", "r_word.data", b, r_word.data);
		check_eq("framing", "r_word.frame_err", 1, r_word.frame_err);
		// First bad stop bit since reset
		check_eq("framing", "frame_err_cnt", 1, status.frame_err_cnt);
		pop_word();
	endtask

	task automatic overrun_then_clear();
		logic [7:0] bytes [0:9];
		int i;
		for (i = 0; i < 10; i++)
			bytes[i] = $urandom & 8'hff;
		// Without reads the last two frames hit a full FIFO
		for (i = 0; i < 10; i++)
			drive_frame(bytes[i], 1'b1);
		@(negedge clk);
		check_eq("overrun", "overrun_cnt", 2, status.overrun_cnt);
		for (i = 0; i < 8; i++)
			expect_word("overrun", bytes[i], 1'b0);
		@(negedge clk);
		check_eq("overrun", "rx_empty", 1, rx_empty);
		write_cfg(CFG_ADDR_CLR, '0);
		@(negedge clk);
		check_eq("overrun", "status after clear", 0, status);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		seed = 17076;
		void'($urandom(seed));
		rst_n    = 1'b0;
		wr_uart  = 1'b0;
		w_data   = '0;
		rd_uart  = 1'b0;
		cfg      = '0;
		loop_sel = 1'b1;
		drv_line = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_state();
		loopback_one_byte();
		burst_in_order();
		framing_error_frame();
		overrun_then_clear();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rx,
	input  logic               tick,
	output logic               rx_done,
	output uart_pkg::rx_word_t rx_word
);
	import uart_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} state_t;

	state_t                        state;
	logic                          rx_meta;
	logic                          rx_s;
	logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
	logic [$clog2(DATA_BITS)-1:0]  bit_cnt;
	logic [DATA_BITS-1:0]          shreg;
	// Stop bit already sampled, waiting for line high
	logic                          stop_seen;
	logic                          mid_start;
	logic                          bit_end;

	//////////////////////////////
	// Input synchronizer
	//////////////////////////////

	// Reset to idle level so no false start
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_s    <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
		end
	end

	// Middle of start bit, then every 16 ticks
	assign mid_start = tick && (tick_cnt == OVERSAMPLE/2 - 1);
	assign bit_end   = tick && (tick_cnt == OVERSAMPLE - 1);

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			stop_seen <= 1'b0;
			rx_done   <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			// Counter wraps 15 -> 0 on its own
			if (tick)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				IDLE: begin
					if (!rx_s) begin
						state    <= START;
						tick_cnt <= '0;
					end
				end
				START: begin
					if (mid_start) begin
						// Line back high means a glitch
						state    <= rx_s ? IDLE : DATA;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end
				end
				DATA: begin
					if (bit_end) begin
						if (bit_cnt == DATA_BITS - 1)
							state <= STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				STOP: begin
					if (stop_seen) begin
						// Hold off until the low stop bit ends
						if (rx_s) begin
							state     <= IDLE;
							stop_seen <= 1'b0;
						end
					end else if (bit_end) begin
						// Word goes out even on a bad stop bit
						rx_done <= 1'b1;
						if (rx_s)
							state <= IDLE;
						else
							stop_seen <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Data path
	//////////////////////////////

	always_ff @(posedge clk) begin
		// LSB first, shift in from the top
		if ((state == DATA) && bit_end)
			shreg <= {rx_s, shreg[DATA_BITS-1:1]};
		if ((state == STOP) && !stop_seen && bit_end) begin
			rx_word.data      <= shreg;
			rx_word.frame_err <= !rx_s;
		end
	end

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           tick,
	input  logic                           fifo_empty,
	input  logic [uart_pkg::DATA_BITS-1:0] fifo_data,
	output logic                           tx_pop,
	output logic                           tx
);
	import uart_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} state_t;

	state_t                        state;
	logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
	logic [$clog2(DATA_BITS)-1:0]  bit_cnt;
	// Frame byte, held for the whole frame
	logic [DATA_BITS-1:0]          shreg;
	logic                          bit_end;

	// Frame starts on a tick with data waiting
	// Pop and latch on the same edge
	assign tx_pop  = (state == IDLE) && tick && !fifo_empty;
	assign bit_end = tick && (tick_cnt == OVERSAMPLE - 1);

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
		end else begin
			// 16 ticks per bit, wraps by itself
			if (tick)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				IDLE: begin
					tx <= 1'b1;
					if (tx_pop) begin
						state    <= START;
						tick_cnt <= '0;
						// Start bit
						tx <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						state   <= DATA;
						bit_cnt <= '0;
						tx      <= shreg[0];
					end
				end
				DATA: begin
					if (bit_end) begin
						if (bit_cnt == DATA_BITS - 1) begin
							state <= STOP;
							// Stop bit
							tx <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							tx      <= shreg[bit_cnt + 1'b1];
						end
					end
				end
				STOP: begin
					if (bit_end)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Data latch
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (tx_pop)
			shreg <= fifo_data;
	end

endmodule
